// File: rtl/lc4_alu.sv
`timescale 1ns/10ps

module lc4_alu (
    input  lc4_pkg::word_t   i_insn,
    input  lc4_pkg::word_t   i_pc,
    input  lc4_pkg::word_t   i_rs_data,
    input  lc4_pkg::word_t   i_rt_data,
    input  lc4_pkg::alu_op_e i_op,
    output lc4_pkg::word_t   o_result
);

    lc4_pkg::word_t imm5_sext;
    lc4_pkg::word_t imm6_sext;
    lc4_pkg::word_t imm9_sext;
    lc4_pkg::word_t pc_plus_one;

    assign imm5_sext   = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6_sext   = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9_sext   = {{7{i_insn[8]}}, i_insn[8:0]};
    assign pc_plus_one = i_pc + 16'd1;

    always_comb begin
        case (i_op)
            lc4_pkg::alu_add: begin
                o_result = i_rs_data + i_rt_data;
            end
            lc4_pkg::alu_sub: begin
                o_result = i_rs_data - i_rt_data;
            end
            lc4_pkg::alu_and: begin
                o_result = i_rs_data & i_rt_data;
            end
            lc4_pkg::alu_addi: begin
                o_result = i_rs_data + imm5_sext;
            end
            lc4_pkg::alu_const: begin
                o_result = imm9_sext;
            end
            lc4_pkg::alu_addr: begin
                o_result = i_rs_data + imm6_sext;  // ldr/str effective address
            end
            lc4_pkg::alu_brtgt: begin
                o_result = pc_plus_one + imm9_sext;
            end
            default: begin
                o_result = '0;
            end
        endcase
    end

endmodule

// File: rtl/lc4_decoder.sv
`timescale 1ns/10ps

module lc4_decoder (
    input  lc4_pkg::word_t    i_insn,
    output lc4_pkg::reg_sel_t o_rs,
    output lc4_pkg::reg_sel_t o_rt,
    output lc4_pkg::reg_sel_t o_wsel,
    output logic              o_rs_re,
    output logic              o_rt_re,
    output logic              o_regfile_we,
    output logic              o_nzp_we,
    output logic              o_is_load,
    output logic              o_is_store,
    output logic              o_is_branch,
    output lc4_pkg::alu_op_e  o_alu_op
);

    lc4_pkg::opcode_t opcode;
    logic             writes_rd;  // result goes to rd and sets nzp

    assign opcode       = i_insn[15:12];
    assign o_regfile_we = writes_rd;
    assign o_nzp_we     = writes_rd;

    always_comb begin
        o_rs        = i_insn[8:6];
        o_rt        = i_insn[2:0];
        o_wsel      = i_insn[11:9];
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        writes_rd   = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;
        o_alu_op    = lc4_pkg::alu_add;
        case (opcode)
            lc4_pkg::OP_BR: begin
                o_is_branch = 1'b1;  // nzp 000 is never taken
                o_alu_op    = lc4_pkg::alu_brtgt;
            end
            lc4_pkg::OP_ARITH: begin
                if (i_insn[5]) begin
                    o_rs_re   = 1'b1;
                    writes_rd = 1'b1;
                    o_alu_op  = lc4_pkg::alu_addi;
                end else if (i_insn[4:3] == 2'b00 || i_insn[4:3] == 2'b10) begin
                    o_rs_re   = 1'b1;
                    o_rt_re   = 1'b1;
                    writes_rd = 1'b1;
                    o_alu_op  = i_insn[4] ? lc4_pkg::alu_sub : lc4_pkg::alu_add;
                end  // mul and div fall through as nop
            end
            lc4_pkg::OP_AND: begin
                if (i_insn[5:3] == 3'b000) begin
                    o_rs_re   = 1'b1;
                    o_rt_re   = 1'b1;
                    writes_rd = 1'b1;
                    o_alu_op  = lc4_pkg::alu_and;
                end
            end
            lc4_pkg::OP_LDR: begin
                o_rs_re   = 1'b1;
                writes_rd = 1'b1;
                o_is_load = 1'b1;
                o_alu_op  = lc4_pkg::alu_addr;
            end
            lc4_pkg::OP_STR: begin
                o_rt       = i_insn[11:9];  // store data register
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
                o_alu_op   = lc4_pkg::alu_addr;
            end
            lc4_pkg::OP_CONST: begin
                writes_rd = 1'b1;
                o_alu_op  = lc4_pkg::alu_const;
            end
            default: ;
        endcase
    end

endmodule

// File: rtl/lc4_fetch.sv
`timescale 1ns/10ps

module lc4_fetch (
    input  logic          gwe,
    input  logic          i_reset,
    input  logic          i_hold,      // load-to-use stall
    input  logic          i_redirect,  // taken branch in execute
    input  lc4_pkg::word_t i_target,
    output lc4_pkg::word_t o_pc
);

    lc4_pkg::word_t pc_next;

    // a redirect never meets a hold: the stall needs a load in execute,
    // the redirect a branch there
    always_comb begin
        if (i_redirect) begin
            pc_next = i_target;
        end else if (i_hold) begin
            pc_next = o_pc;
        end else begin
            pc_next = o_pc + 16'd1;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_pc <= lc4_pkg::RESET_PC;
        end else begin
            o_pc <= pc_next;
        end
    end

endmodule

// File: rtl/lc4_hazard.sv
`timescale 1ns/10ps

module lc4_hazard (
    input  lc4_pkg::reg_sel_t i_d_rs,
    input  lc4_pkg::reg_sel_t i_d_rt,
    input  lc4_pkg::reg_sel_t i_x_rs,
    input  lc4_pkg::reg_sel_t i_x_rt,
    input  lc4_pkg::reg_sel_t i_x_wsel,
    input  lc4_pkg::reg_sel_t i_m_wsel,
    input  lc4_pkg::reg_sel_t i_m_rt,
    input  lc4_pkg::reg_sel_t i_w_wsel,
    input  logic              i_d_rs_re,
    input  logic              i_d_rt_re,
    input  logic              i_d_is_store,
    input  logic              i_d_is_branch,
    input  logic              i_x_is_load,
    input  logic              i_x_branch_taken,
    input  logic              i_m_regfile_we,
    input  logic              i_m_is_store,
    input  logic              i_w_regfile_we,
    output logic              o_stall,
    output logic              o_flush,
    output logic [1:0]        o_rs_src,
    output logic [1:0]        o_rt_src,
    output logic              o_wm_bypass,
    output lc4_pkg::stall_e   o_x_stall_code
);

    logic rs_dep;
    logic rt_dep;

    // newest producer wins, so memory stage is checked before writeback
    function automatic logic [1:0] pick_src(
        input lc4_pkg::reg_sel_t sel,
        input logic              m_we,
        input lc4_pkg::reg_sel_t m_wsel,
        input logic              w_we,
        input lc4_pkg::reg_sel_t w_wsel
    );
        if (m_we && m_wsel == sel) begin
            return lc4_pkg::SRC_M;
        end else if (w_we && w_wsel == sel) begin
            return lc4_pkg::SRC_W;
        end
        return lc4_pkg::SRC_NONE;
    endfunction

    assign rs_dep = i_d_rs_re && (i_d_rs == i_x_wsel);
    assign rt_dep = i_d_rt_re && !i_d_is_store && (i_d_rt == i_x_wsel);  // store data uses WM

    // a branch reads nzp, which a load only sets at the end of memory
    assign o_stall = i_x_is_load && (rs_dep || rt_dep || i_d_is_branch);
    assign o_flush = i_x_branch_taken;

    assign o_rs_src = pick_src(i_x_rs, i_m_regfile_we, i_m_wsel, i_w_regfile_we, i_w_wsel);
    assign o_rt_src = pick_src(i_x_rt, i_m_regfile_we, i_m_wsel, i_w_regfile_we, i_w_wsel);

    assign o_wm_bypass = i_m_is_store && i_w_regfile_we && (i_m_rt == i_w_wsel);

    always_comb begin
        if (o_flush) begin
            o_x_stall_code = lc4_pkg::stall_flush;
        end else if (o_stall) begin
            o_x_stall_code = lc4_pkg::stall_load;
        end else begin
            o_x_stall_code = lc4_pkg::stall_none;  // decode slot keeps its own code
        end
    end

endmodule

// File: rtl/lc4_pipeline.sv
`timescale 1ns/10ps

module lc4_pipeline (
    input  logic              gwe,
    input  logic              i_reset,
    output lc4_pkg::word_t    o_cur_pc,
    input  lc4_pkg::word_t    i_cur_insn,
    output lc4_pkg::word_t    o_dmem_addr,
    input  lc4_pkg::word_t    i_cur_dmem_data,
    output logic              o_dmem_we,
    output lc4_pkg::word_t    o_dmem_towrite,
    output lc4_pkg::stall_e   o_test_stall,
    output lc4_pkg::word_t    o_test_pc,
    output lc4_pkg::word_t    o_test_insn,
    output logic              o_test_regfile_we,
    output lc4_pkg::reg_sel_t o_test_regfile_wsel,
    output lc4_pkg::word_t    o_test_regfile_data,
    output logic              o_test_nzp_we,
    output lc4_pkg::nzp_t     o_test_nzp_bits,
    output logic              o_test_dmem_we,
    output lc4_pkg::word_t    o_test_dmem_addr,
    output lc4_pkg::word_t    o_test_dmem_data
);

    lc4_pkg::word_t    f_pc, d_insn, d_pc, d_rs_data, d_rt_data;
    lc4_pkg::stall_e   d_stall, hz_code, x_stall_next, x_stall, m_stall, w_stall;
    lc4_pkg::reg_sel_t d_rs, d_rt, d_wsel, x_rs, x_rt, x_wsel, m_wsel, m_rt, w_wsel;
    lc4_pkg::alu_op_e  d_alu_op, x_alu_op;
    logic d_rs_re, d_rt_re, d_regfile_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
    logic d_valid, x_take, stall, flush, wm_bypass, branch_taken, m_mem_access;
    logic x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
    logic m_regfile_we, m_nzp_we, m_is_load, m_is_store;
    logic w_regfile_we, w_nzp_we, w_is_load, w_is_store;
    logic [1:0] rs_src, rt_src;
    lc4_pkg::word_t x_pc, x_insn, x_rs_data, x_rt_data, x_rs_val, x_rt_val, alu_result;
    lc4_pkg::word_t m_pc, m_insn, m_result, m_rt_data, m_store_data, m_mem_data;
    lc4_pkg::word_t w_pc, w_insn, w_result, w_load_data, w_dmem_addr, w_dmem_data, w_wdata;
    lc4_pkg::nzp_t  nzp_reg, x_nzp, m_nzp, m_load_nzp, w_nzp;

    function automatic lc4_pkg::nzp_t nzp_of(input lc4_pkg::word_t v);
        if (v[15]) return 3'b100;
        if (v == '0) return 3'b010;
        return 3'b001;
    endfunction

    lc4_fetch fetch_i (.gwe(gwe), .i_reset(i_reset), .i_hold(stall), .i_redirect(branch_taken),
                       .i_target(alu_result), .o_pc(f_pc));

    always_ff @(posedge gwe) begin  // decode slot code
        if (i_reset || flush) d_stall <= lc4_pkg::stall_flush;
        else if (!stall) d_stall <= lc4_pkg::stall_none;
    end
    always_ff @(posedge gwe) begin
        if (!stall) begin
            d_insn <= i_cur_insn;
            d_pc   <= f_pc;
        end
    end
    assign d_valid = (d_stall == lc4_pkg::stall_none);

    lc4_decoder decoder_i (.i_insn(d_insn), .o_rs(d_rs), .o_rt(d_rt), .o_wsel(d_wsel),
                           .o_rs_re(d_rs_re), .o_rt_re(d_rt_re), .o_regfile_we(d_regfile_we),
                           .o_nzp_we(d_nzp_we), .o_is_load(d_is_load), .o_is_store(d_is_store),
                           .o_is_branch(d_is_branch), .o_alu_op(d_alu_op));

    lc4_regfile regfile_i (.gwe(gwe), .i_reset(i_reset), .i_rs(d_rs), .i_rt(d_rt),
                           .i_rd(w_wsel), .i_wdata(w_wdata), .i_we(w_regfile_we),
                           .o_rs_data(d_rs_data), .o_rt_data(d_rt_data));

    lc4_hazard hazard_i (.i_d_rs(d_rs), .i_d_rt(d_rt), .i_x_rs(x_rs), .i_x_rt(x_rt),
        .i_x_wsel(x_wsel), .i_m_wsel(m_wsel), .i_m_rt(m_rt), .i_w_wsel(w_wsel),
        .i_d_rs_re(d_rs_re), .i_d_rt_re(d_rt_re), .i_d_is_store(d_is_store),
        .i_d_is_branch(d_is_branch), .i_x_is_load(x_is_load), .i_x_branch_taken(branch_taken),
        .i_m_regfile_we(m_regfile_we), .i_m_is_store(m_is_store),
        .i_w_regfile_we(w_regfile_we), .o_stall(stall), .o_flush(flush), .o_rs_src(rs_src),
        .o_rt_src(rt_src), .o_wm_bypass(wm_bypass), .o_x_stall_code(hz_code));

    // bubble into execute on stall or flush, otherwise the decode slot moves on
    assign x_take       = d_valid && !stall && !flush;
    assign x_stall_next = (hz_code != lc4_pkg::stall_none) ? hz_code : d_stall;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            {x_regfile_we, x_nzp_we, x_is_load, x_is_store, x_is_branch} <= '0;
            x_stall <= lc4_pkg::stall_flush;
        end else begin
            x_regfile_we <= d_regfile_we && x_take;
            x_nzp_we     <= d_nzp_we && x_take;
            x_is_load    <= d_is_load && x_take;
            x_is_store   <= d_is_store && x_take;
            x_is_branch  <= d_is_branch && x_take;
            x_stall      <= x_stall_next;
        end
    end
    always_ff @(posedge gwe) begin
        {x_rs, x_rt, x_wsel, x_alu_op} <= {d_rs, d_rt, d_wsel, d_alu_op};
        {x_pc, x_insn, x_rs_data, x_rt_data} <= {d_pc, d_insn, d_rs_data, d_rt_data};
    end

    // MX / WX operand bypass
    assign x_rs_val = (rs_src == lc4_pkg::SRC_M) ? m_result :
                      (rs_src == lc4_pkg::SRC_W) ? w_wdata : x_rs_data;
    assign x_rt_val = (rt_src == lc4_pkg::SRC_M) ? m_result :
                      (rt_src == lc4_pkg::SRC_W) ? w_wdata : x_rt_data;

    lc4_alu alu_i (.i_insn(x_insn), .i_pc(x_pc), .i_rs_data(x_rs_val), .i_rt_data(x_rt_val),
                   .i_op(x_alu_op), .o_result(alu_result));

    assign x_nzp        = nzp_of(alu_result);
    assign branch_taken = x_is_branch && ((nzp_reg & x_insn[11:9]) != 3'b000);

    always_ff @(posedge gwe) begin
        if (i_reset) nzp_reg <= 3'b000;
        else if (x_nzp_we && !x_is_load) nzp_reg <= x_nzp;  // younger insn wins
        else if (m_is_load) nzp_reg <= m_load_nzp;
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            {m_regfile_we, m_nzp_we, m_is_load, m_is_store} <= '0;
            m_stall <= lc4_pkg::stall_flush;
        end else begin
            {m_regfile_we, m_nzp_we, m_is_load, m_is_store} <=
                {x_regfile_we, x_nzp_we, x_is_load, x_is_store};
            m_stall <= x_stall;
        end
    end
    always_ff @(posedge gwe) begin
        {m_wsel, m_rt, m_nzp} <= {x_wsel, x_rt, x_nzp};
        {m_pc, m_insn, m_result, m_rt_data} <= {x_pc, x_insn, alu_result, x_rt_val};
    end

    // memory stage, store data may come from the load now in writeback
    assign m_mem_access   = m_is_load || m_is_store;
    assign m_store_data   = wm_bypass ? w_wdata : m_rt_data;
    assign m_load_nzp     = nzp_of(i_cur_dmem_data);
    assign o_dmem_addr    = m_mem_access ? m_result : '0;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = m_is_store ? m_store_data : '0;
    assign m_mem_data     = m_is_load ? i_cur_dmem_data : o_dmem_towrite;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            {w_regfile_we, w_nzp_we, w_is_load, w_is_store} <= '0;
            w_stall <= lc4_pkg::stall_flush;
        end else begin
            {w_regfile_we, w_nzp_we, w_is_load, w_is_store} <=
                {m_regfile_we, m_nzp_we, m_is_load, m_is_store};
            w_stall <= m_stall;
        end
    end
    always_ff @(posedge gwe) begin
        w_wsel <= m_wsel;
        w_nzp  <= m_is_load ? m_load_nzp : m_nzp;
        {w_pc, w_insn, w_result, w_load_data} <= {m_pc, m_insn, m_result, i_cur_dmem_data};
        {w_dmem_addr, w_dmem_data} <= {o_dmem_addr, m_mem_data};
    end

    assign w_wdata = w_is_load ? w_load_data : w_result;

    assign o_cur_pc            = f_pc;
    assign o_test_stall        = w_stall;
    assign o_test_pc           = w_pc;
    assign o_test_insn         = w_insn;
    assign o_test_regfile_we   = w_regfile_we;
    assign o_test_regfile_wsel = w_wsel;
    assign o_test_regfile_data = w_wdata;
    assign o_test_nzp_we       = w_nzp_we;
    assign o_test_nzp_bits     = w_nzp;
    assign o_test_dmem_we      = w_is_store;
    assign o_test_dmem_addr    = w_dmem_addr;
    assign o_test_dmem_data    = w_dmem_data;

endmodule

// File: rtl/lc4_pkg.sv
package lc4_pkg;

    // datapath widths
    localparam int WORD_W    = 16;
    localparam int REG_SEL_W = 3;
    localparam int NUM_REGS  = 8;

    typedef logic [WORD_W-1:0]    word_t;     // data word, address or instruction
    typedef logic [REG_SEL_W-1:0] reg_sel_t;  // register number
    typedef logic [2:0]           nzp_t;      // n, z, p
    typedef logic [3:0]           opcode_t;   // insn[15:12]

    // opcodes of the supported subset
    localparam opcode_t OP_BR    = 4'b0000;
    localparam opcode_t OP_ARITH = 4'b0001;
    localparam opcode_t OP_AND   = 4'b0101;
    localparam opcode_t OP_LDR   = 4'b0110;
    localparam opcode_t OP_STR   = 4'b0111;
    localparam opcode_t OP_CONST = 4'b1001;

    localparam word_t RESET_PC = 16'h8200;  // first fetch address

    // operand source selects from the hazard unit
    localparam logic [1:0] SRC_NONE = 2'd0;  // value read in decode
    localparam logic [1:0] SRC_M    = 2'd1;  // ALU result in memory stage
    localparam logic [1:0] SRC_W    = 2'd2;  // writeback data

    // stall code carried with every slot down to writeback
    // code 1 belonged to the second pipe and is never produced
    typedef enum logic [1:0] {
        stall_none  = 2'd0,
        stall_flush = 2'd2,
        stall_load  = 2'd3
    } stall_e;

    typedef enum logic [2:0] {
        alu_add,    // rs + rt
        alu_sub,    // rs - rt
        alu_and,    // rs & rt
        alu_addi,   // rs + imm5
        alu_const,  // imm9
        alu_addr,   // rs + imm6, load/store address
        alu_brtgt   // pc + 1 + imm9
    } alu_op_e;

endpackage

// File: rtl/lc4_regfile.sv
`timescale 1ns/10ps

module lc4_regfile (
    input  logic              gwe,
    input  logic              i_reset,
    input  lc4_pkg::reg_sel_t i_rs,
    input  lc4_pkg::reg_sel_t i_rt,
    input  lc4_pkg::reg_sel_t i_rd,
    input  lc4_pkg::word_t    i_wdata,
    input  logic              i_we,
    output lc4_pkg::word_t    o_rs_data,
    output lc4_pkg::word_t    o_rt_data
);

    lc4_pkg::word_t regs [lc4_pkg::NUM_REGS];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < lc4_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_rd] <= i_wdata;
        end
    end

    // write-through: decode sees the value writeback is storing this cycle
    assign o_rs_data = (i_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: run.sh
#!/bin/sh
# compile and run the LC4 pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module lc4_tb \
    --Mdir obj_dir -o lc4_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit $status
fi

./obj_dir/lc4_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// File: tb.f
rtl/lc4_pkg.sv
rtl/lc4_fetch.sv
rtl/lc4_decoder.sv
rtl/lc4_regfile.sv
rtl/lc4_alu.sv
rtl/lc4_hazard.sv
rtl/lc4_pipeline.sv
testbench/lc4_pipeline_chk.sv
testbench/lc4_tb.sv

// File: testbench/lc4_pipeline_chk.sv
`timescale 1ns/10ps

module lc4_pipeline_chk (
    input logic            gwe,
    input logic            i_reset,
    input logic            i_dmem_we,
    input lc4_pkg::word_t  i_m_insn,
    input lc4_pkg::stall_e i_m_stall,
    input lc4_pkg::stall_e i_test_stall,
    input logic            i_test_regfile_we,
    input logic            i_test_nzp_we,
    input logic            i_test_dmem_we
);

    // the strobe belongs to a live str in the memory stage
    dmem_we_from_store: assert property (@(posedge gwe)
        i_dmem_we |-> (i_m_insn[15:12] == lc4_pkg::OP_STR) &&
                      (i_m_stall == lc4_pkg::stall_none))
        else $error("data memory written without a store in the memory stage");

    // code 1 belonged to the second pipe
    stall_code_legal: assert property (@(posedge gwe) disable iff (i_reset)
        i_test_stall != 2'd1)
        else $error("illegal stall code at writeback");

    bubble_writes_nothing: assert property (@(posedge gwe)
        i_test_stall != lc4_pkg::stall_none |->
            !i_test_regfile_we && !i_test_nzp_we && !i_test_dmem_we)
        else $error("bubble at writeback carries a write enable");

endmodule

bind lc4_pipeline lc4_pipeline_chk chk_i (
    .gwe(gwe),
    .i_reset(i_reset),
    .i_dmem_we(o_dmem_we),
    .i_m_insn(m_insn),
    .i_m_stall(m_stall),
    .i_test_stall(o_test_stall),
    .i_test_regfile_we(o_test_regfile_we),
    .i_test_nzp_we(o_test_nzp_we),
    .i_test_dmem_we(o_test_dmem_we)
);

// File: testbench/lc4_tb.sv
`timescale 1ns/10ps

module lc4_tb;

    localparam int PROG_LEN   = 64;
    localparam int DMEM_DEPTH = 256;
    localparam int MAX_TRACE  = 400;

    // four flush cycles follow reset and the first one ends before sampling starts
    localparam int RESET_FLUSH_SEEN = 3;

    // one committed instruction as the ISA sees it
    typedef struct packed {
        lc4_pkg::word_t    pc;
        lc4_pkg::word_t    insn;
        logic              rf_we;
        lc4_pkg::reg_sel_t wsel;
        lc4_pkg::word_t    rf_data;
        logic              nzp_we;
        lc4_pkg::nzp_t     nzp;
        logic              dmem_we;
        lc4_pkg::word_t    dmem_addr;
        lc4_pkg::word_t    dmem_data;
        logic              taken;
        logic              is_load;
        logic [1:0]        n_flush;  // bubbles expected just before it
        logic [1:0]        n_load;
    } entry_t;

    logic gwe;
    logic i_reset;
    logic dmem_we, test_regfile_we, test_nzp_we, test_dmem_we;
    lc4_pkg::word_t    cur_pc, cur_insn, dmem_addr, cur_dmem_data, dmem_towrite, imem_off;
    lc4_pkg::word_t    test_pc, test_insn, test_regfile_data, test_dmem_addr, test_dmem_data;
    lc4_pkg::reg_sel_t test_regfile_wsel;
    lc4_pkg::nzp_t     test_nzp_bits;
    lc4_pkg::stall_e   test_stall;

    lc4_pkg::word_t prog [PROG_LEN];
    lc4_pkg::word_t dmem [DMEM_DEPTH];
    lc4_pkg::word_t ref_dmem [DMEM_DEPTH];
    lc4_pkg::word_t ref_regs [lc4_pkg::NUM_REGS];
    lc4_pkg::nzp_t  ref_nzp;
    logic [15:0]    lfsr;
    entry_t         trace [$];
    int             error_count;
    bit             trace_ready;

    lc4_pipeline dut_i (
        .gwe(gwe), .i_reset(i_reset), .o_cur_pc(cur_pc), .i_cur_insn(cur_insn),
        .o_dmem_addr(dmem_addr), .i_cur_dmem_data(cur_dmem_data), .o_dmem_we(dmem_we),
        .o_dmem_towrite(dmem_towrite), .o_test_stall(test_stall), .o_test_pc(test_pc),
        .o_test_insn(test_insn), .o_test_regfile_we(test_regfile_we),
        .o_test_regfile_wsel(test_regfile_wsel), .o_test_regfile_data(test_regfile_data),
        .o_test_nzp_we(test_nzp_we), .o_test_nzp_bits(test_nzp_bits),
        .o_test_dmem_we(test_dmem_we), .o_test_dmem_addr(test_dmem_addr),
        .o_test_dmem_data(test_dmem_data)
    );

    initial gwe = 1'b0;
    always #10 gwe = ~gwe;

    // instruction memory from 0x8200 with nop outside the program
    assign imem_off      = cur_pc - lc4_pkg::RESET_PC;
    assign cur_insn      = (imem_off < 16'd64) ? prog[imem_off[5:0]] : 16'h0000;
    assign cur_dmem_data = dmem[dmem_addr[7:0]];

    always @(negedge gwe) begin
        if (dmem_we) dmem[dmem_addr[7:0]] = dmem_towrite;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // galois form
    endfunction

    task automatic draw_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic make_program();
        logic [15:0] kind, rd, rs, rt, imm, nzp, off;
        int          limit;
        lfsr = 16'd31;
        draw_bits(9, imm);
        prog[0] = {lc4_pkg::OP_CONST, 3'd1, imm[8:0]};  // nzp is never 000 after this
        for (int i = 1; i < PROG_LEN - 2; i++) begin
            draw_bits(3, kind);
            draw_bits(2, rd);
            draw_bits(2, rs);
            draw_bits(2, rt);
            case (kind[2:0])
                3'd0: prog[i] = {lc4_pkg::OP_ARITH, 1'b0, rd[1:0], 1'b0, rs[1:0], 3'b000,
                                 1'b0, rt[1:0]};
                3'd1: prog[i] = {lc4_pkg::OP_ARITH, 1'b0, rd[1:0], 1'b0, rs[1:0], 3'b010,
                                 1'b0, rt[1:0]};
                3'd2: prog[i] = {lc4_pkg::OP_AND, 1'b0, rd[1:0], 1'b0, rs[1:0], 3'b000,
                                 1'b0, rt[1:0]};
                3'd3: begin
                    draw_bits(5, imm);
                    prog[i] = {lc4_pkg::OP_ARITH, 1'b0, rd[1:0], 1'b0, rs[1:0], 1'b1, imm[4:0]};
                end
                3'd4: begin
                    draw_bits(9, imm);
                    prog[i] = {lc4_pkg::OP_CONST, 1'b0, rd[1:0], imm[8:0]};
                end
                3'd5, 3'd6: begin
                    draw_bits(6, imm);
                    prog[i] = {(kind[0] ? lc4_pkg::OP_LDR : lc4_pkg::OP_STR), 1'b0, rd[1:0],
                               1'b0, rs[1:0], imm[5:0]};
                end
                default: begin
                    draw_bits(3, nzp);
                    draw_bits(2, off);
                    limit = PROG_LEN - 2 - i;  // stay inside the program
                    if (int'(off) > limit) off = 16'(limit);
                    prog[i] = {lc4_pkg::OP_BR, nzp[2:0], 7'd0, off[1:0]};
                end
            endcase
        end
        prog[PROG_LEN-2] = {lc4_pkg::OP_CONST, 3'd0, 9'd0};
        prog[PROG_LEN-1] = {lc4_pkg::OP_BR, 3'b111, 9'h1ff};  // branch to itself
    endtask

    function automatic lc4_pkg::nzp_t sign_class(input lc4_pkg::word_t v);
        if (v[15]) return 3'b100;
        return (v == 16'd0) ? 3'b010 : 3'b001;
    endfunction

    // ISA interpreter for one instruction
    function automatic entry_t ref_execute(input lc4_pkg::word_t pc, input lc4_pkg::word_t insn);
        entry_t         e;
        lc4_pkg::word_t a, b, r, addr;
        logic           wr;
        e      = '0;
        e.pc   = pc;
        e.insn = insn;
        e.wsel = insn[11:9];
        a      = ref_regs[insn[8:6]];
        b      = ref_regs[insn[2:0]];
        r      = '0;
        wr     = 1'b1;
        addr   = a + {{10{insn[5]}}, insn[5:0]};
        case (insn[15:12])
            lc4_pkg::OP_ARITH: r = insn[5] ? a + {{11{insn[4]}}, insn[4:0]} :
                                   (insn[4] ? a - b : a + b);
            lc4_pkg::OP_AND:   r = a & b;
            lc4_pkg::OP_CONST: r = {{7{insn[8]}}, insn[8:0]};
            lc4_pkg::OP_LDR: begin
                r           = ref_dmem[addr[7:0]];
                e.is_load   = 1'b1;
                e.dmem_addr = addr;
                e.dmem_data = r;
            end
            lc4_pkg::OP_STR: begin
                wr                   = 1'b0;
                e.dmem_we            = 1'b1;
                e.dmem_addr          = addr;
                e.dmem_data          = ref_regs[insn[11:9]];
                ref_dmem[addr[7:0]] = e.dmem_data;
            end
            default: begin
                wr      = 1'b0;
                e.taken = (ref_nzp & insn[11:9]) != 3'b000;
            end
        endcase
        if (wr) begin
            e.rf_we              = 1'b1;
            e.rf_data            = r;
            e.nzp_we             = 1'b1;
            e.nzp                = sign_class(r);
            ref_regs[insn[11:9]] = r;
            ref_nzp              = e.nzp;
        end
        return e;
    endfunction

    // would this instruction need the value of a load just ahead of it
    function automatic logic needs_load(input lc4_pkg::word_t insn, input lc4_pkg::reg_sel_t r);
        case (insn[15:12])
            lc4_pkg::OP_BR: return 1'b1;  // reads nzp
            lc4_pkg::OP_ARITH,
            lc4_pkg::OP_AND: return insn[8:6] == r || (!insn[5] && insn[2:0] == r);
            lc4_pkg::OP_LDR,
            lc4_pkg::OP_STR: return insn[8:6] == r;  // store data comes by WM
            default: return 1'b0;
        endcase
    endfunction

    task automatic build_trace();
        lc4_pkg::word_t pc, off;
        entry_t         e, prev;
        int             loops;
        pc      = lc4_pkg::RESET_PC;
        loops   = 0;
        ref_nzp = 3'b000;
        for (int i = 0; i < lc4_pkg::NUM_REGS; i++) ref_regs[i] = '0;
        while (loops < 3 && trace.size() < MAX_TRACE) begin
            off = pc - lc4_pkg::RESET_PC;
            e   = ref_execute(pc, prog[off[5:0]]);
            if (trace.size() > 0) begin
                prev = trace[$];
                if (prev.taken) e.n_flush = 2'd2;
                if (prev.is_load && needs_load(e.insn, prev.wsel)) e.n_load = 2'd1;
            end
            if (off == 16'(PROG_LEN - 1)) loops++;
            pc = e.taken ? pc + 16'd1 + {{7{e.insn[8]}}, e.insn[8:0]} : pc + 16'd1;
            trace.push_back(e);
        end
    endtask

    task automatic fail_run();
        error_count++;
        $display("=== FAIL ===");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string name, input lc4_pkg::word_t got,
                              input lc4_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_sel(input string name, input lc4_pkg::reg_sel_t got,
                             input lc4_pkg::reg_sel_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_nzp(input string name, input lc4_pkg::nzp_t got,
                             input lc4_pkg::nzp_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_stall(input string name, input lc4_pkg::stall_e got,
                               input lc4_pkg::stall_e exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_bubbles(input int idx, input int n_flush, input int n_load);
        if (idx == 0 && (n_flush != RESET_FLUSH_SEEN || n_load != 0)) begin
            $display("first commit came after %0d flush and %0d load bubbles", n_flush, n_load);
            fail_run();
        end else if (idx > 0 && (n_flush != int'(trace[idx].n_flush) ||
                                 n_load != int'(trace[idx].n_load))) begin
            $display("pc %h came after %0d flush and %0d load bubbles, expected %0d and %0d",
                     trace[idx].pc, n_flush, n_load, trace[idx].n_flush, trace[idx].n_load);
            fail_run();
        end
    endtask

    initial begin
        wait (trace_ready);
        #((20 + 4 * trace.size()) * 20);
        $display("timeout, writeback stopped before the end of the trace");
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    // writeback compare
    initial begin
        entry_t e;
        int     idx, n_flush, n_load;
        i_reset     = 1'b1;
        error_count = 0;
        for (int i = 0; i < DMEM_DEPTH; i++) begin
            dmem[i]     = {8'(i) ^ 8'h5a, ~8'(i)};
            ref_dmem[i] = dmem[i];
        end
        make_program();
        build_trace();
        trace_ready = 1'b1;
        repeat (3) @(posedge gwe);
        @(negedge gwe);
        i_reset = 1'b0;
        idx     = 0;
        n_flush = 0;
        n_load  = 0;
        while (idx < trace.size()) begin
            @(negedge gwe);
            if (test_stall != lc4_pkg::stall_none) begin
                check_bit("o_test_regfile_we", test_regfile_we, 1'b0);
                check_bit("o_test_nzp_we", test_nzp_we, 1'b0);
                check_bit("o_test_dmem_we", test_dmem_we, 1'b0);
                if (test_stall == lc4_pkg::stall_flush) n_flush++;
                else if (test_stall == lc4_pkg::stall_load) n_load++;
                else check_stall("o_test_stall", test_stall, lc4_pkg::stall_flush);
            end else begin
                e = trace[idx];
                check_bubbles(idx, n_flush, n_load);
                check_word("o_test_pc", test_pc, e.pc);
                check_word("o_test_insn", test_insn, e.insn);
                check_bit("o_test_regfile_we", test_regfile_we, e.rf_we);
                if (e.rf_we) begin
                    check_sel("o_test_regfile_wsel", test_regfile_wsel, e.wsel);
                    check_word("o_test_regfile_data", test_regfile_data, e.rf_data);
                end
                check_bit("o_test_nzp_we", test_nzp_we, e.nzp_we);
                if (e.nzp_we) check_nzp("o_test_nzp_bits", test_nzp_bits, e.nzp);
                check_bit("o_test_dmem_we", test_dmem_we, e.dmem_we);
                check_word("o_test_dmem_addr", test_dmem_addr, e.dmem_addr);
                check_word("o_test_dmem_data", test_dmem_data, e.dmem_data);
                idx++;
                n_flush = 0;
                n_load  = 0;
            end
        end
        for (int i = 0; i < DMEM_DEPTH; i++) check_word("dmem", dmem[i], ref_dmem[i]);
        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule
